// File: alu_imm_iq_stimulus.txt
# name attempt op_way0 op_way1 op_way2 op_way3 pipeline_ready wb_bus(bank3..bank0)
#   then expected: dispatch_ack issue_valid issue_op prf_req, all hex
fill_empty       F 101116041 20221A082 30331E0C3 404422104 0 00000 F 0 00000000 00
fill_rest        F 505534145 606601186 7077481C7 808826208 0 00000 F 0 00000000 00
full_no_ack      3 90992A249 A0AA2E28A 000000000 000000000 0 00000 0 0 00000000 00
issue_when_full  1 90992A249 000000000 000000000 000000000 1 00000 0 1 10111041 45
one_free_entry   3 90992A249 A0AA2E28A 000000000 000000000 0 00000 1 0 00000000 00
stall_wakeup     0 000000000 000000000 000000000 000000000 0 00260 0 0 00000000 00
resume_first     0 000000000 000000000 000000000 000000000 1 00000 0 1 20222082 46
resume_second    0 000000000 000000000 000000000 000000000 1 00000 0 1 303330C3 47
resume_third     0 000000000 000000000 000000000 000000000 1 00000 0 1 40440104 48
latched_ready    0 000000000 000000000 000000000 000000000 1 00000 0 1 50551145 4D
zero_operand     0 000000000 000000000 000000000 000000000 1 00000 0 1 60664186 00
wrong_bank       0 000000000 000000000 000000000 000000000 1 00280 0 1 80881208 49
wakeup_forward   1 B0BB3E2CB 000000000 000000000 000000000 1 05000 1 1 7077A1C7 12
collapse_order   0 000000000 000000000 000000000 000000000 1 00000 0 1 90992249 4A
collapse_last    0 000000000 000000000 000000000 000000000 1 00000 0 1 B0BB32CB 4F
dispatch_empty   1 C0CC4230C 000000000 000000000 000000000 1 00000 1 0 00000000 00
next_cycle_issue 0 000000000 000000000 000000000 000000000 1 00000 0 1 C0CC030C 50
drain_idle       0 000000000 000000000 000000000 000000000 1 00000 0 0 00000000 00

// File: sim.f
iq_pkg.sv
iq_dispatch_alloc.sv
iq_issue_select.sv
iq_entry_array.sv
alu_imm_iq.sv
alu_imm_iq_assertions.sv
tb_alu_imm_iq.sv

// File: run_sim.sh
#!/bin/sh
# build the issue queue testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_alu_imm_iq \
    -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 || { cat sim.log; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// File: tb_alu_imm_iq.sv
// issue queue testbench
`timescale 1ns/1ns

module tb_alu_imm_iq;

    import iq_pkg::*;

    localparam int IQ_ENTRIES    = 8;
    localparam int DISPATCH_WAYS = 4;
    localparam int RESET_TIMEOUT = 20;
    localparam int MAX_LINES     = 200;

    logic                          CLK;
    logic                          nRST;
    logic [DISPATCH_WAYS-1:0]      dispatch_attempt;
    iq_op_t [DISPATCH_WAYS-1:0]    dispatch_op;
    logic [DISPATCH_WAYS-1:0]      dispatch_ack;
    logic                          pipeline_ready;
    wb_bus_t [PRF_BANK_COUNT-1:0]  wb_bus;
    logic                          issue_valid;
    iq_issue_t                     issue_op;
    prf_req_t                      prf_req;

    int checks;
    int value_errors;
    int other_errors;

    alu_imm_iq #(
        .IQ_ENTRIES    (IQ_ENTRIES),
        .DISPATCH_WAYS (DISPATCH_WAYS)
    ) alu_imm_iq_i (
        .CLK              (CLK),
        .nRST             (nRST),
        .dispatch_attempt (dispatch_attempt),
        .dispatch_op      (dispatch_op),
        .dispatch_ack     (dispatch_ack),
        .pipeline_ready   (pipeline_ready),
        .wb_bus           (wb_bus),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .prf_req          (prf_req)
    );

    bind alu_imm_iq alu_imm_iq_assertions #(
        .DISPATCH_WAYS (DISPATCH_WAYS)
    ) assertions_i (
        .CLK              (CLK),
        .nRST             (nRST),
        .dispatch_attempt (dispatch_attempt),
        .dispatch_ack     (dispatch_ack),
        .pipeline_ready   (pipeline_ready),
        .issue_valid      (issue_valid),
        .prf_req          (prf_req)
    );

    // ----------------------------------------
    // clock and reset

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

    // ----------------------------------------
    // compare tasks

    task automatic ack_check(input string test, input logic [DISPATCH_WAYS-1:0] expected,
                             input logic [DISPATCH_WAYS-1:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %s: dispatch_ack expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic issue_check(input string test, input iq_issue_t expected,
                               input iq_issue_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %s: issue_op expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic prf_check(input string test, input prf_req_t expected,
                             input prf_req_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %s: prf_req expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic flag_check(input string test, input string what, input logic expected,
                              input logic actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %s: %s expected %b actual %b", test, what, expected, actual);
        end
    endtask

    // blank lines and comment lines carry no cycle
    function automatic bit data_line(input string line);
        return line.len() > 1 && line[0] != "#";
    endfunction

    // ----------------------------------------
    // stimulus and checking

    initial begin
        int                         fd;
        int                         status;
        int                         fields;
        int                         lines_read;
        int                         wait_cycles;
        int                         assert_errors;
        string                      line;
        string                      test_name;
        logic [DISPATCH_WAYS-1:0]   att_word;
        logic [$bits(iq_op_t)-1:0]  op_word [DISPATCH_WAYS];
        logic                       ready_word;
        logic [$bits(wb_bus)-1:0]   wb_word;
        logic [DISPATCH_WAYS-1:0]   ack_word;
        logic                       valid_word;
        iq_issue_t                  exp_issue;
        prf_req_t                   exp_prf;

        checks           = 0;
        value_errors     = 0;
        other_errors     = 0;
        dispatch_attempt = '0;
        dispatch_op      = '0;
        pipeline_ready   = 1'b0;
        wb_bus           = '0;

        fd = $fopen("alu_imm_iq_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file alu_imm_iq_stimulus.txt");
            other_errors++;
        end

        wait_cycles = 0;
        while (nRST !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge CLK);
            wait_cycles++;
        end

        if (nRST !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            other_errors++;
        end else if (fd != 0) begin
            // empty queue offers nothing even to a ready pipeline
            @(negedge CLK);
            pipeline_ready = 1'b1;
            #4;
            ack_check("after_reset", '0, dispatch_ack);
            flag_check("after_reset", "issue_valid", 1'b0, issue_valid);
            flag_check("after_reset", "prf_req.valid", 1'b0, prf_req.valid);

            lines_read = 0;
            while (!$feof(fd) && lines_read < MAX_LINES) begin
                line = "";
                status = $fgets(line, fd);
                lines_read++;
                if (status > 0 && data_line(line)) begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                        test_name, att_word, op_word[0], op_word[1], op_word[2], op_word[3],
                        ready_word, wb_word, ack_word, valid_word, exp_issue, exp_prf);
                    if (fields != 12) begin
                        $display("stimulus line could not be parsed: %s", line);
                        other_errors++;
                    end else begin
                        @(negedge CLK);
                        dispatch_attempt = att_word;
                        for (int w = 0; w < DISPATCH_WAYS; w++) begin
                            dispatch_op[w] = op_word[w];
                        end
                        pipeline_ready = ready_word;
                        wb_bus         = wb_word;

                        // outputs settle well before the next rising edge
                        #4;
                        ack_check(test_name, ack_word, dispatch_ack);
                        flag_check(test_name, "issue_valid", valid_word, issue_valid);
                        if (valid_word) begin
                            issue_check(test_name, exp_issue, issue_op);
                            prf_check(test_name, exp_prf, prf_req);
                        end else begin
                            flag_check(test_name, "prf_req.valid", exp_prf.valid,
                                prf_req.valid);
                        end
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("stimulus file not finished after %0d lines", MAX_LINES);
                other_errors++;
            end
            $fclose(fd);
        end

        @(negedge CLK);
        dispatch_attempt = '0;
        pipeline_ready   = 1'b0;
        wb_bus           = '0;
        @(negedge CLK);

        assert_errors = alu_imm_iq_i.assertions_i.fail_count;
        $display("checks %0d, value errors %0d, assertion errors %0d, other errors %0d",
            checks, value_errors, assert_errors, other_errors);
        if (value_errors + assert_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: alu_imm_iq_assertions.sv
// issue queue port assertions
`timescale 1ns/1ns

module alu_imm_iq_assertions #(
    parameter int DISPATCH_WAYS = 4
) (
    input logic                     CLK,
    input logic                     nRST,
    input logic [DISPATCH_WAYS-1:0] dispatch_attempt,
    input logic [DISPATCH_WAYS-1:0] dispatch_ack,
    input logic                     pipeline_ready,
    input logic                     issue_valid,
    input iq_pkg::prf_req_t         prf_req
);

    // failed assertions so far, read by the testbench
    int unsigned fail_count = 0;

    // issue only into a ready pipeline
    issue_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> pipeline_ready)
    else begin
        $error("issue_valid high while pipeline_ready is low");
        fail_count++;
    end

    // a register read belongs to an issue
    read_needs_issue: assert property (@(posedge CLK) disable iff (!nRST)
        prf_req.valid |-> issue_valid)
    else begin
        $error("prf_req valid without issue_valid");
        fail_count++;
    end

    ack_needs_attempt: assert property (@(posedge CLK) disable iff (!nRST)
        (dispatch_ack & ~dispatch_attempt) == '0)
    else begin
        $error("dispatch_ack given to a way that did not attempt");
        fail_count++;
    end

endmodule

// File: alu_imm_iq.sv
// ALU register-immediate issue queue
`timescale 1ns/1ns

module alu_imm_iq #(
    parameter int IQ_ENTRIES    = 8,
    parameter int DISPATCH_WAYS = 4
) (
    input  logic                                         CLK,
    input  logic                                         nRST,

    // dispatch by way
    input  logic [DISPATCH_WAYS-1:0]                     dispatch_attempt,
    input  iq_pkg::iq_op_t [DISPATCH_WAYS-1:0]           dispatch_op,
    output logic [DISPATCH_WAYS-1:0]                     dispatch_ack,

    // pipeline and writeback
    input  logic                                         pipeline_ready,
    input  iq_pkg::wb_bus_t [iq_pkg::PRF_BANK_COUNT-1:0] wb_bus,

    // issue and register read
    output logic                                         issue_valid,
    output iq_pkg::iq_issue_t                            issue_op,
    output iq_pkg::prf_req_t                             prf_req
);

    import iq_pkg::*;

    logic [IQ_ENTRIES-1:0]   entry_valid;
    iq_op_t [IQ_ENTRIES-1:0] entry_op;
    logic [IQ_ENTRIES-1:0]   issue_mask;
    logic [IQ_ENTRIES-1:0]   a_forward;
    logic [IQ_ENTRIES-1:0]   dispatch_valid_by_entry;
    iq_op_t [IQ_ENTRIES-1:0] dispatch_op_by_entry;

    iq_dispatch_alloc #(
        .IQ_ENTRIES    (IQ_ENTRIES),
        .DISPATCH_WAYS (DISPATCH_WAYS)
    ) dispatch_alloc_i (
        .entry_valid             (entry_valid),
        .dispatch_attempt        (dispatch_attempt),
        .dispatch_op             (dispatch_op),
        .dispatch_ack            (dispatch_ack),
        .dispatch_valid_by_entry (dispatch_valid_by_entry),
        .dispatch_op_by_entry    (dispatch_op_by_entry)
    );

    iq_issue_select #(
        .IQ_ENTRIES (IQ_ENTRIES)
    ) issue_select_i (
        .pipeline_ready (pipeline_ready),
        .wb_bus         (wb_bus),
        .entry_valid    (entry_valid),
        .entry_op       (entry_op),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .prf_req        (prf_req),
        .issue_mask     (issue_mask),
        .a_forward      (a_forward)
    );

    iq_entry_array #(
        .IQ_ENTRIES (IQ_ENTRIES)
    ) entry_array_i (
        .CLK                     (CLK),
        .nRST                    (nRST),
        .issue_mask              (issue_mask),
        .a_forward               (a_forward),
        .dispatch_valid_by_entry (dispatch_valid_by_entry),
        .dispatch_op_by_entry    (dispatch_op_by_entry),
        .entry_valid             (entry_valid),
        .entry_op                (entry_op)
    );

endmodule

// File: iq_entry_array.sv
// issue queue collapsing entry storage
`timescale 1ns/1ns

module iq_entry_array #(
    parameter int IQ_ENTRIES = 8
) (
    input  logic                             CLK,
    input  logic                             nRST,

    // from issue select
    input  logic [IQ_ENTRIES-1:0]            issue_mask,
    input  logic [IQ_ENTRIES-1:0]            a_forward,

    // from dispatch allocation
    input  logic [IQ_ENTRIES-1:0]            dispatch_valid_by_entry,
    input  iq_pkg::iq_op_t [IQ_ENTRIES-1:0]  dispatch_op_by_entry,

    // stored state, entry 0 is the oldest
    output logic [IQ_ENTRIES-1:0]            entry_valid,
    output iq_pkg::iq_op_t [IQ_ENTRIES-1:0]  entry_op
);

    import iq_pkg::*;

    logic [IQ_ENTRIES-1:0]   next_valid;
    iq_op_t [IQ_ENTRIES-1:0] next_op;

    // ----------------------------------------
    // next state for lower entries

    // each may shift down from above or stay
    always_comb begin
        for (int i = 0; i < IQ_ENTRIES-1; i++) begin
            if (issue_mask[i]) begin
                if (entry_valid[i+1]) begin
                    // shift stored entry down, keeping any wakeup
                    next_valid[i]      = 1'b1;
                    next_op[i]         = entry_op[i+1];
                    next_op[i].a_ready = entry_op[i+1].a_ready | a_forward[i+1];
                end else begin
                    // dispatch routed above lands here instead
                    next_valid[i] = dispatch_valid_by_entry[i+1];
                    next_op[i]    = dispatch_op_by_entry[i+1];
                end
            end else if (entry_valid[i]) begin
                next_valid[i]      = 1'b1;
                next_op[i]         = entry_op[i];
                next_op[i].a_ready = entry_op[i].a_ready | a_forward[i];
            end else begin
                next_valid[i] = dispatch_valid_by_entry[i];
                next_op[i]    = dispatch_op_by_entry[i];
            end
        end

        // ----------------------------------------
        // top entry has nothing above

        if (issue_mask[IQ_ENTRIES-1]) begin
            next_valid[IQ_ENTRIES-1] = 1'b0;
            next_op[IQ_ENTRIES-1]    = entry_op[IQ_ENTRIES-1];
        end else if (entry_valid[IQ_ENTRIES-1]) begin
            next_valid[IQ_ENTRIES-1]      = 1'b1;
            next_op[IQ_ENTRIES-1]         = entry_op[IQ_ENTRIES-1];
            next_op[IQ_ENTRIES-1].a_ready = entry_op[IQ_ENTRIES-1].a_ready
                | a_forward[IQ_ENTRIES-1];
        end else begin
            next_valid[IQ_ENTRIES-1] = dispatch_valid_by_entry[IQ_ENTRIES-1];
            next_op[IQ_ENTRIES-1]    = dispatch_op_by_entry[IQ_ENTRIES-1];
        end
    end

    // ----------------------------------------
    // entry flops

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            entry_valid <= '0;
            entry_op    <= '0;
        end else begin
            entry_valid <= next_valid;
            entry_op    <= next_op;
        end
    end

endmodule

// File: iq_issue_select.sv
// issue queue wakeup and issue select
`timescale 1ns/1ns

module iq_issue_select #(
    parameter int IQ_ENTRIES = 8
) (
    // pipeline and writeback
    input  logic                                        pipeline_ready,
    input  iq_pkg::wb_bus_t [iq_pkg::PRF_BANK_COUNT-1:0] wb_bus,

    // stored entries
    input  logic [IQ_ENTRIES-1:0]                       entry_valid,
    input  iq_pkg::iq_op_t [IQ_ENTRIES-1:0]             entry_op,

    // issue to pipeline and register read
    output logic                                        issue_valid,
    output iq_pkg::iq_issue_t                           issue_op,
    output iq_pkg::prf_req_t                            prf_req,

    // back to entry array
    output logic [IQ_ENTRIES-1:0]                       issue_mask,
    output logic [IQ_ENTRIES-1:0]                       a_forward
);

    import iq_pkg::*;

    logic [IQ_ENTRIES-1:0]    ready;
    logic [IQ_ENTRIES-1:0]    operand_ok;
    logic [IQ_ENTRIES-1:0]    issue_one_hot;
    logic [LSB_MAX_WIDTH-1:0] ready_wide;
    logic [LSB_MAX_WIDTH-1:0] one_hot_wide;

    // ----------------------------------------
    // wakeup

    // compare a_pr against the tag of its own bank
    always_comb begin
        logic [LOG_PRF_BANK_COUNT-1:0] bank;

        for (int i = 0; i < IQ_ENTRIES; i++) begin
            bank = entry_op[i].a_pr[LOG_PRF_BANK_COUNT-1:0];
            a_forward[i] = wb_bus[bank].valid
                & (wb_bus[bank].upper_pr == entry_op[i].a_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
            operand_ok[i] = entry_op[i].a_ready | a_forward[i] | entry_op[i].a_is_zero;
        end
    end

    assign ready = {IQ_ENTRIES{pipeline_ready}} & entry_valid & operand_ok;

    // ----------------------------------------
    // oldest ready select

    always_comb begin
        ready_wide = '0;
        ready_wide[IQ_ENTRIES-1:0] = ready;
    end

    assign one_hot_wide  = lsb_one_hot(ready_wide);
    assign issue_one_hot = one_hot_wide[IQ_ENTRIES-1:0];
    assign issue_valid   = |ready;

    // issued entry and everything above it collapses
    always_comb begin
        issue_mask[0] = issue_one_hot[0];
        for (int i = 1; i < IQ_ENTRIES; i++) begin
            issue_mask[i] = issue_mask[i-1] | issue_one_hot[i];
        end
    end

    // one-hot mux of the issued entry
    always_comb begin
        issue_op = '0;
        prf_req  = '0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (issue_one_hot[i]) begin
                issue_op.op        |= entry_op[i].op;
                issue_op.imm12     |= entry_op[i].imm12;
                issue_op.a_forward |= a_forward[i];
                issue_op.a_is_zero |= entry_op[i].a_is_zero;
                issue_op.a_bank    |= entry_op[i].a_pr[LOG_PRF_BANK_COUNT-1:0];
                issue_op.dest_pr   |= entry_op[i].dest_pr;
                issue_op.rob_index |= entry_op[i].rob_index;
                // no read when forwarded or zero
                prf_req.valid      |= ~a_forward[i] & ~entry_op[i].a_is_zero;
                prf_req.pr         |= entry_op[i].a_pr;
            end
        end
    end

endmodule

// File: iq_dispatch_alloc.sv
// issue queue dispatch allocation
`timescale 1ns/1ns

module iq_dispatch_alloc #(
    parameter int IQ_ENTRIES    = 8,
    parameter int DISPATCH_WAYS = 4
) (
    // entry occupancy at start of cycle
    input  logic [IQ_ENTRIES-1:0]                    entry_valid,

    // dispatch by way
    input  logic [DISPATCH_WAYS-1:0]                 dispatch_attempt,
    input  iq_pkg::iq_op_t [DISPATCH_WAYS-1:0]       dispatch_op,
    output logic [DISPATCH_WAYS-1:0]                 dispatch_ack,

    // dispatch routed by entry
    output logic [IQ_ENTRIES-1:0]                    dispatch_valid_by_entry,
    output iq_pkg::iq_op_t [IQ_ENTRIES-1:0]          dispatch_op_by_entry
);

    import iq_pkg::*;

    // entry taken by each way, zero if the way gets none
    logic [DISPATCH_WAYS-1:0][IQ_ENTRIES-1:0] take_one_hot;

    // ----------------------------------------
    // cascaded allocation

    always_comb begin
        logic [IQ_ENTRIES-1:0]    open_mask;
        logic [LSB_MAX_WIDTH-1:0] open_wide;
        logic [LSB_MAX_WIDTH-1:0] pick_wide;

        open_mask = ~entry_valid;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            open_wide = '0;
            open_wide[IQ_ENTRIES-1:0] = open_mask;
            pick_wide = lsb_one_hot(open_wide);

            // only an attempting way claims its entry
            take_one_hot[w] = pick_wide[IQ_ENTRIES-1:0] & {IQ_ENTRIES{dispatch_attempt[w]}};
            dispatch_ack[w] = |take_one_hot[w];

            // hide the claimed entry from higher ways
            open_mask = open_mask & ~take_one_hot[w];
        end
    end

    // ----------------------------------------
    // way to entry routing

    // one-hot mux over ways at each entry
    always_comb begin
        dispatch_valid_by_entry = '0;
        dispatch_op_by_entry    = '0;
        for (int e = 0; e < IQ_ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                if (take_one_hot[w][e]) begin
                    dispatch_valid_by_entry[e] = 1'b1;
                    dispatch_op_by_entry[e]    = dispatch_op_by_entry[e] | dispatch_op[w];
                end
            end
        end
    end

endmodule

// File: iq_pkg.sv
// issue queue shared definitions

package iq_pkg;

    // ----------------------------------------
    // sizes

    localparam int LOG_PR_COUNT       = 6;
    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int LOG_ROB_ENTRIES    = 6;
    localparam int OP_WIDTH           = 4;
    localparam int IMM_WIDTH          = 12;

    // widest vector the priority function handles
    localparam int LSB_MAX_WIDTH      = 64;

    // ----------------------------------------
    // packed structs

    // renamed operation as dispatched, 36 bits
    typedef struct packed {
        logic [OP_WIDTH-1:0]        op;
        logic [IMM_WIDTH-1:0]       imm12;
        logic [LOG_PR_COUNT-1:0]    a_pr;
        logic                       a_ready;
        logic                       a_is_zero;
        logic [LOG_PR_COUNT-1:0]    dest_pr;
        logic [LOG_ROB_ENTRIES-1:0] rob_index;
    } iq_op_t;

    // operation handed to the ALU pipeline, 32 bits
    typedef struct packed {
        logic [OP_WIDTH-1:0]           op;
        logic [IMM_WIDTH-1:0]          imm12;
        logic                          a_forward;
        logic                          a_is_zero;
        logic [LOG_PRF_BANK_COUNT-1:0] a_bank;
        logic [LOG_PR_COUNT-1:0]       dest_pr;
        logic [LOG_ROB_ENTRIES-1:0]    rob_index;
    } iq_issue_t;

    // register file read request
    typedef struct packed {
        logic                    valid;
        logic [LOG_PR_COUNT-1:0] pr;
    } prf_req_t;

    // writeback tag of one bank, register number without bank bits
    typedef struct packed {
        logic                                       valid;
        logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr;
    } wb_bus_t;

    // lowest set bit of vec, as one-hot
    function automatic logic [LSB_MAX_WIDTH-1:0] lsb_one_hot(
        input logic [LSB_MAX_WIDTH-1:0] vec
    );
        return vec & (~vec + 1'b1);
    endfunction

endpackage
